// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := mips_tb
RTL_TOP   := mips
FILELIST  := mips.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Passes only when the testbench prints its pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== mips.f ====
+incdir+verilog
verilog/mips_pkg.sv
verilog/mips_if.sv
verilog/reg_file.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/hazard_unit.sv
verilog/mips.sv
test/mips_assertions.sv
test/mips_tb.sv

// ==== test/mips_assertions.sv ====
/* Protocol checks on the memory strobes and the fetch address of mips.
   Attached to the core by bind from the testbench. */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_assertions (
	input logic                    clock,
	input logic                    rst,
	input logic [`MIPS_WORD_W-1:0] instruction_address,
	input logic                    mem_read,
	input logic                    mem_write,
	input logic                    stall,
	input logic                    branch_taken,
	input logic [`MIPS_WORD_W-1:0] branch_target
);

	// One data access per cycle
	strobes_exclusive: assert property (@(posedge clock) disable iff (rst)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high in the same cycle");

	// Synchronous reset clears both strobes
	strobes_idle_in_reset: assert property (@(posedge clock)
		rst |=> (!mem_read && !mem_write))
		else $error("memory strobe active during reset");

	fetch_aligned: assert property (@(posedge clock) disable iff (rst)
		instruction_address[1:0] == 2'b00)
		else $error("instruction_address not word aligned");

	// Redirect first, then stall hold, else next word
	fetch_sequence: assert property (@(posedge clock) disable iff (rst)
		$past(!rst) |->
			($past(branch_taken) ? instruction_address == $past(branch_target)
			: $past(stall) ? instruction_address == $past(instruction_address)
			: instruction_address == $past(instruction_address) + `MIPS_WORD_W'd4))
		else $error("instruction_address broke the fetch sequence");

endmodule

// ==== test/mips_tb.sv ====
/* Testbench for mips. Program, initial data and expected stores come
   from test/mips_tests.txt; both memories are modelled here. */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_tb;

	localparam int MEM_WORDS    = 256;
	localparam int IDX_W        = $clog2(MEM_WORDS);
	localparam int CLOCK_HALF   = 50;
	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DELAY  = 1;
	localparam int QUIET_CYCLES = 20;

	logic                    clock;
	logic                    rst;
	logic [`MIPS_WORD_W-1:0] instruction_in;
	logic [`MIPS_WORD_W-1:0] data_in;
	logic [`MIPS_WORD_W-1:0] instruction_address;
	logic [`MIPS_WORD_W-1:0] data_address;
	logic [`MIPS_WORD_W-1:0] data_out;
	logic                    mem_read;
	logic                    mem_write;

	// Word-indexed memories
	logic [`MIPS_WORD_W-1:0] imem [MEM_WORDS];
	logic [`MIPS_WORD_W-1:0] dmem [MEM_WORDS];

	// Expected stores in program order
	logic [`MIPS_WORD_W-1:0] exp_addr [$];
	logic [`MIPS_WORD_W-1:0] exp_data [$];
	int                      store_idx;
	int                      program_lines;
	int                      cycles;
	int                      cycle_limit;

	mips uut (
		.clock               (clock),
		.rst                 (rst),
		.instruction_in      (instruction_in),
		.data_in             (data_in),
		.instruction_address (instruction_address),
		.data_address        (data_address),
		.data_out            (data_out),
		.mem_read            (mem_read),
		.mem_write           (mem_write)
	);

	bind mips mips_assertions protocol_checks (
		.clock               (clock),
		.rst                 (rst),
		.instruction_address (instruction_address),
		.mem_read            (mem_read),
		.mem_write           (mem_write),
		.stall               (stall),
		.branch_taken        (branch_taken),
		.branch_target       (branch_target)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_HALF) clock = ~clock;
	end

	//------------------------------------------------------------
	// Reporting and compare tasks
	//------------------------------------------------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(
		input string                   name,
		input logic [`MIPS_WORD_W-1:0] expected,
		input logic [`MIPS_WORD_W-1:0] actual
	);
		if (actual !== expected)
			abort_run($sformatf("ERR time %0t: %s expected %h, actual %h",
				$time, name, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("ERR time %0t: %s expected %b, actual %b",
				$time, name, expected, actual));
	endtask

	// Byte address to memory row
	function automatic int word_index(input logic [`MIPS_WORD_W-1:0] byte_addr);
		return int'(byte_addr[IDX_W+1:2]);
	endfunction

	//------------------------------------------------------------
	// Test file and memory model
	//------------------------------------------------------------
	task automatic load_tests();
		int                      fd;
		int                      fields;
		string                   line;
		logic [`MIPS_WORD_W-1:0] addr;
		logic [`MIPS_WORD_W-1:0] word;
		// Unloaded program words are no-ops, data follows its address
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = '0;
			dmem[i] = ~(i * 4);
		end
		fd = $fopen("test/mips_tests.txt", "r");
		if (fd == 0)
			abort_run("Cannot open test/mips_tests.txt");
		program_lines = 0;
		while ($fgets(line, fd) != 0) begin
			// Blank lines and comments
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, word);
			if (fields != 2)
				abort_run($sformatf("Malformed line in test file: %s", line));
			case (line.getc(0))
				"I": begin
					imem[word_index(addr)] = word;
					program_lines++;
				end
				"M": dmem[word_index(addr)] = word;
				"S": begin
					exp_addr.push_back(addr);
					exp_data.push_back(word);
				end
				default: abort_run($sformatf("Unknown line kind in test file: %s", line));
			endcase
		end
		$fclose(fd);
		if (program_lines == 0 || exp_addr.size() == 0)
			abort_run("Test file holds no program or no expected stores");
	endtask

	// Next expected store, then memory update
	task automatic record_store();
		if (store_idx >= exp_addr.size()) begin
			abort_run($sformatf("Unexpected extra store to address %h at time %0t",
				data_address, $time));
		end else begin
			check_word("data_address", exp_addr[store_idx], data_address);
			check_word("data_out", exp_data[store_idx], data_out);
			dmem[word_index(data_address)] = data_out;
			store_idx++;
		end
	endtask

	// One clock: outputs settled, memories answer the new addresses
	task automatic service_cycle();
		@(posedge clock);
		#(DRIVE_DELAY);
		cycles++;
		check_bit("mem_read & mem_write", 1'b0, mem_read & mem_write);
		if (mem_write)
			record_store();
		instruction_in = imem[word_index(instruction_address)];
		data_in        = mem_read ? dmem[word_index(data_address)] : '0;
		if (cycles >= cycle_limit && store_idx < exp_addr.size())
			abort_run("Timeout: the expected stores did not all appear");
	endtask

	task automatic check_reset_state();
		check_word("instruction_address", `MIPS_RESET_PC, instruction_address);
		check_bit("mem_read", 1'b0, mem_read);
		check_bit("mem_write", 1'b0, mem_write);
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial begin
		rst            = 1'b1;
		instruction_in = '0;
		data_in        = '0;
		store_idx      = 0;
		cycles         = 0;
		load_tests();
		cycle_limit = 8 * program_lines + 40;

		repeat (RESET_CYCLES) begin
			service_cycle();
			check_reset_state();
		end
		rst = 1'b0;
		// First edge out of reset, nothing has reached memory yet
		service_cycle();
		check_word("instruction_address", `MIPS_RESET_PC + `MIPS_WORD_W'd4,
			instruction_address);
		check_bit("mem_read", 1'b0, mem_read);
		check_bit("mem_write", 1'b0, mem_write);

		while (store_idx < exp_addr.size())
			service_cycle();
		// Squashed or stray stores would show up here
		repeat (QUIET_CYCLES)
			service_cycle();

		$display("Test passed");
		$finish;
	end

endmodule

// ==== test/mips_tests.txt ====
# Columns: kind (I program word, M initial data, S expected store), hex byte address, hex word
# S lines list address and data in program order, text after the word is a note

# Dependent ALU chain through both forward paths
I 00000000 2401005a addiu r1, r0, 0x5a
I 00000004 24220033 addiu r2, r1, 0x33
I 00000008 00221821 addu  r3, r1, r2
I 0000000c 00612023 subu  r4, r3, r1
I 00000010 00832824 and   r5, r4, r3
I 00000014 00a13025 or    r6, r5, r1
I 00000018 2408fffd addiu r8, r0, -3
I 0000001c 0106382a slt   r7, r8, r6
I 00000020 ac070100 sw    r7, 0x100(r0)
I 00000024 00c8482a slt   r9, r6, r8
I 00000028 ac090104 sw    r9, 0x104(r0)
I 0000002c ac030108 sw    r3, 0x108(r0)
I 00000030 ac04010c sw    r4, 0x10c(r0)
I 00000034 ac050110 sw    r5, 0x110(r0)
I 00000038 ac060114 sw    r6, 0x114(r0)
# Load-use into an ALU source, then into store data
I 0000003c 8c2a01a6 lw    r10, 0x1a6(r1)
I 00000040 01425821 addu  r11, r10, r2
I 00000044 ac0b0118 sw    r11, 0x118(r0)
I 00000048 8c0c0204 lw    r12, 0x204(r0)
I 0000004c ac0c011c sw    r12, 0x11c(r0)
# Branch not taken, then taken over two stores
I 00000050 10220004 beq   r1, r2, +4
I 00000054 ac010120 sw    r1, 0x120(r0)
I 00000058 10440002 beq   r2, r4, +2
I 0000005c ac030124 sw    r3, 0x124(r0)
I 00000060 ac040128 sw    r4, 0x128(r0)
I 00000064 ac05012c sw    r5, 0x12c(r0)
# Program end, loops on itself
I 00000068 1000ffff beq   r0, r0, -1

M 00000200 12345600
M 00000204 cafef00d

S 00000100 00000001 slt of -3 and 0xdf
S 00000104 00000000 slt of 0xdf and -3
S 00000108 000000e7
S 0000010c 0000008d
S 00000110 00000085
S 00000114 000000df
S 00000118 1234568d loaded word plus r2
S 0000011c cafef00d
S 00000120 0000005a after the beq that is not taken
S 0000012c 00000085 branch target

// ==== verilog/decode.sv ====
/* Instruction decode, register read and control generation,
   ending in the decode/execute latch. Stall or flush loads a bubble. */
`timescale 1ns/1ps
`include "mips_settings.svh"

module decode (
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    stall,
	input  logic                    flush,
	input  mips_pkg::instr_t        id_instr,
	input  logic [`MIPS_WORD_W-1:0] id_pc_plus4,
	stage_result_if.monitor         wb,
	output logic [`MIPS_WORD_W-1:0] ex_operand_a,
	output logic [`MIPS_WORD_W-1:0] ex_operand_b,
	output logic [`MIPS_WORD_W-1:0] ex_store_data,
	output logic [`MIPS_WORD_W-1:0] ex_imm,
	output logic                    ex_use_imm,
	output mips_pkg::alu_op_t       ex_alu_op,
	output logic [`MIPS_REG_AW-1:0] ex_rs,
	output logic [`MIPS_REG_AW-1:0] ex_rt,
	output logic [`MIPS_REG_AW-1:0] ex_dest,
	output logic                    ex_reg_write,
	output logic                    ex_mem_read,
	output logic                    ex_mem_write,
	output logic                    ex_branch,
	output logic [`MIPS_WORD_W-1:0] ex_pc_plus4,
	output logic [`MIPS_REG_AW-1:0] id_rs,
	output logic [`MIPS_REG_AW-1:0] id_rt
);

	import mips_pkg::*;

	logic [`MIPS_WORD_W-1:0] rs_value;
	logic [`MIPS_WORD_W-1:0] rt_value;
	logic [`MIPS_WORD_W-1:0] imm;
	logic [`MIPS_REG_AW-1:0] dest;
	alu_op_t                 alu_op;
	logic                    use_imm;
	logic                    reg_write;
	logic                    mem_read;
	logic                    mem_write;
	logic                    branch;

	// Source fields, rs from the R view and rt from the I view
	assign id_rs = id_instr.r.rs;
	assign id_rt = id_instr.i.rt;
	assign imm   = {{(`MIPS_WORD_W - 16){id_instr.i.imm[15]}}, id_instr.i.imm};

	// Write port fed by the memory/writeback latch
	reg_file regs (
		.clock      (clock),
		.rst        (rst),
		.read_a     (id_rs),
		.read_b     (id_rt),
		.write_en   (wb.valid && wb.reg_write),
		.write_addr (wb.dest),
		.write_data (wb.value),
		.value_a    (rs_value),
		.value_b    (rt_value)
	);

	//------------------------------------------------------------
	// Control decode
	//------------------------------------------------------------
	always_comb begin
		use_imm   = 1'b0;
		alu_op    = ALU_ADD;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		branch    = 1'b0;
		dest      = id_instr.r.rd;
		case (id_instr.r.opcode)
			OP_SPECIAL: begin
				reg_write = 1'b1;
				case (id_instr.r.funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					// Unsupported function, no effect
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				use_imm   = 1'b1;
				reg_write = 1'b1;
				dest      = id_instr.i.rt;
			end
			OP_LW: begin
				use_imm   = 1'b1;
				reg_write = 1'b1;
				mem_read  = 1'b1;
				dest      = id_instr.i.rt;
			end
			OP_SW: begin
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			// Compared in execute, ALU result unused
			OP_BEQ: branch = 1'b1;
			default: ;
		endcase
	end

	//------------------------------------------------------------
	// Decode/execute latch
	//------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (rst || stall || flush) begin
			ex_reg_write <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_branch    <= 1'b0;
		end else begin
			ex_reg_write <= reg_write;
			ex_mem_read  <= mem_read;
			ex_mem_write <= mem_write;
			ex_branch    <= branch;
		end
	end

	// Operand B already carries the immediate when one is used
	always_ff @(posedge clock) begin
		ex_operand_a  <= rs_value;
		ex_operand_b  <= use_imm ? imm : rt_value;
		ex_store_data <= rt_value;
		ex_imm        <= imm;
		ex_use_imm    <= use_imm;
		ex_alu_op     <= alu_op;
		ex_rs         <= id_rs;
		ex_rt         <= id_rt;
		ex_dest       <= dest;
		ex_pc_plus4   <= id_pc_plus4;
	end

endmodule

// ==== verilog/execute.sv ====
/* Execute and memory stages: forward muxes, ALU and beq compare,
   then the execute/memory and memory/writeback latches. */
`timescale 1ns/1ps
`include "mips_settings.svh"

module execute (
	input  logic                    clock,
	input  logic                    rst,
	input  logic [`MIPS_WORD_W-1:0] ex_operand_a,
	input  logic [`MIPS_WORD_W-1:0] ex_operand_b,
	input  logic [`MIPS_WORD_W-1:0] ex_store_data,
	input  logic [`MIPS_WORD_W-1:0] ex_imm,
	input  logic                    ex_use_imm,
	input  mips_pkg::alu_op_t       ex_alu_op,
	input  logic [`MIPS_REG_AW-1:0] ex_dest,
	input  logic                    ex_reg_write,
	input  logic                    ex_mem_read,
	input  logic                    ex_mem_write,
	input  logic                    ex_branch,
	input  logic [`MIPS_WORD_W-1:0] ex_pc_plus4,
	input  mips_pkg::fwd_sel_t      sel_a,
	input  mips_pkg::fwd_sel_t      sel_b,
	input  logic [`MIPS_WORD_W-1:0] data_in,
	output logic                    branch_taken,
	output logic [`MIPS_WORD_W-1:0] branch_target,
	output logic [`MIPS_WORD_W-1:0] data_address,
	output logic [`MIPS_WORD_W-1:0] data_out,
	output logic                    mem_read,
	output logic                    mem_write,
	stage_result_if.source          mem_stage,
	stage_result_if.source          wb_stage
);

	import mips_pkg::*;

	logic [`MIPS_WORD_W-1:0] op_a;
	logic [`MIPS_WORD_W-1:0] rt_value;
	logic [`MIPS_WORD_W-1:0] alu_b;
	logic [`MIPS_WORD_W-1:0] alu_result;

	// Pick register value or a younger result
	function automatic logic [`MIPS_WORD_W-1:0] fwd_value(
		input fwd_sel_t                sel,
		input logic [`MIPS_WORD_W-1:0] reg_value
	);
		case (sel)
			FWD_MEM: return mem_stage.value;
			FWD_WB:  return wb_stage.value;
			default: return reg_value;
		endcase
	endfunction

	assign op_a     = fwd_value(sel_a, ex_operand_a);
	// rt feeds the compare, store data and R-type operand B
	assign rt_value = fwd_value(sel_b, ex_store_data);
	assign alu_b    = ex_use_imm ? ex_operand_b : rt_value;

	//------------------------------------------------------------
	// ALU and branch
	//------------------------------------------------------------
	always_comb begin
		case (ex_alu_op)
			ALU_SUB: alu_result = op_a - alu_b;
			ALU_AND: alu_result = op_a & alu_b;
			ALU_OR:  alu_result = op_a | alu_b;
			ALU_SLT: alu_result = {{(`MIPS_WORD_W - 1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			default: alu_result = op_a + alu_b;
		endcase
	end

	assign branch_taken  = ex_branch && (op_a == rt_value);
	// Word offset relative to the delay-free next PC
	assign branch_target = ex_pc_plus4 + {ex_imm[`MIPS_WORD_W-3:0], 2'b00};

	//------------------------------------------------------------
	// Execute/memory latch
	//------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (rst) begin
			mem_stage.reg_write <= 1'b0;
			mem_stage.is_load   <= 1'b0;
			mem_stage.valid     <= 1'b0;
			mem_write           <= 1'b0;
		end else begin
			mem_stage.reg_write <= ex_reg_write;
			mem_stage.is_load   <= ex_mem_read;
			mem_stage.valid     <= ex_reg_write | ex_mem_read | ex_mem_write | ex_branch;
			mem_write           <= ex_mem_write;
		end
	end

	always_ff @(posedge clock) begin
		mem_stage.dest  <= ex_dest;
		mem_stage.value <= alu_result;
		data_out        <= rt_value;
	end

	// Memory side, address straight from the latched ALU result
	assign data_address = mem_stage.value;
	assign mem_read     = mem_stage.is_load;

	//------------------------------------------------------------
	// Memory/writeback latch
	//------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (rst) begin
			wb_stage.reg_write <= 1'b0;
			wb_stage.is_load   <= 1'b0;
			wb_stage.valid     <= 1'b0;
		end else begin
			wb_stage.reg_write <= mem_stage.reg_write;
			wb_stage.is_load   <= mem_stage.is_load;
			wb_stage.valid     <= mem_stage.valid;
		end
	end

	// Loads take memory data
	always_ff @(posedge clock) begin
		wb_stage.dest  <= mem_stage.dest;
		wb_stage.value <= mem_stage.is_load ? data_in : mem_stage.value;
	end

endmodule

// ==== verilog/fetch.sv ====
/* Program counter and fetch/decode latch. Holds on stall,
   redirects on a taken branch and loads a no-op on flush. */
`timescale 1ns/1ps
`include "mips_settings.svh"

module fetch (
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    stall,
	input  logic                    flush,
	input  logic                    branch_taken,
	input  logic [`MIPS_WORD_W-1:0] branch_target,
	input  logic [`MIPS_WORD_W-1:0] instruction_in,
	output logic [`MIPS_WORD_W-1:0] instruction_address,
	output mips_pkg::instr_t        id_instr,
	output logic [`MIPS_WORD_W-1:0] id_pc_plus4
);

	import mips_pkg::*;

	logic [`MIPS_WORD_W-1:0] pc;
	logic [`MIPS_WORD_W-1:0] pc_plus4;

	assign pc_plus4            = pc + `MIPS_WORD_W'd4;
	assign instruction_address = pc;

	// Redirect beats stall
	always_ff @(posedge clock) begin
		if (rst)
			pc <= `MIPS_RESET_PC;
		else if (branch_taken)
			pc <= branch_target;
		else if (!stall)
			pc <= pc_plus4;
	end

	// All-zero word decodes to nothing
	always_ff @(posedge clock) begin
		if (rst || flush)
			id_instr <= '0;
		else if (!stall)
			id_instr <= instruction_in;
	end

	always_ff @(posedge clock) begin
		if (!stall)
			id_pc_plus4 <= pc_plus4;
	end

endmodule

// ==== verilog/hazard_unit.sv ====
/* Combinational hazard logic: forward source selection for the
   execute operands, load-use stall and taken-branch flush. */
`timescale 1ns/1ps
`include "mips_settings.svh"

module hazard_unit (
	input  logic                    [`MIPS_REG_AW-1:0] id_rs,
	input  logic                    [`MIPS_REG_AW-1:0] id_rt,
	input  logic                    [`MIPS_REG_AW-1:0] ex_rs,
	input  logic                    [`MIPS_REG_AW-1:0] ex_rt,
	input  logic                    [`MIPS_REG_AW-1:0] ex_dest,
	input  logic                    ex_mem_read,
	input  logic                    branch_taken,
	stage_result_if.monitor         mem_stage,
	stage_result_if.monitor         wb_stage,
	output mips_pkg::fwd_sel_t      sel_a,
	output mips_pkg::fwd_sel_t      sel_b,
	output logic                    stall,
	output logic                    flush
);

	import mips_pkg::*;

	// Memory latch first, it holds the younger result
	function automatic fwd_sel_t pick(input logic [`MIPS_REG_AW-1:0] src);
		if (src == '0)
			return FWD_REG;
		// A load still in memory has no data yet
		if (mem_stage.valid && mem_stage.reg_write && !mem_stage.is_load && mem_stage.dest == src)
			return FWD_MEM;
		if (wb_stage.valid && wb_stage.reg_write && wb_stage.dest == src)
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign sel_a = pick(ex_rs);
	assign sel_b = pick(ex_rt);

	// Load in execute feeding the instruction in decode
	assign stall = ex_mem_read && ex_dest != '0 && (ex_dest == id_rs || ex_dest == id_rt);

	assign flush = branch_taken;

endmodule

// ==== verilog/mips.sv ====
/* Top of the five-stage MIPS core. Connects the stages, the hazard
   unit and the instruction and data memory ports. */
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips (
	input  logic                    clock,
	input  logic                    rst,
	input  logic [`MIPS_WORD_W-1:0] instruction_in,
	input  logic [`MIPS_WORD_W-1:0] data_in,
	output logic [`MIPS_WORD_W-1:0] instruction_address,
	output logic [`MIPS_WORD_W-1:0] data_address,
	output logic [`MIPS_WORD_W-1:0] data_out,
	output logic                    mem_read,
	output logic                    mem_write
);

	import mips_pkg::*;

	// Hazard control
	logic     stall;
	logic     flush;
	fwd_sel_t sel_a;
	fwd_sel_t sel_b;

	// Fetch to decode
	instr_t                  id_instr;
	logic [`MIPS_WORD_W-1:0] id_pc_plus4;
	logic [`MIPS_REG_AW-1:0] id_rs;
	logic [`MIPS_REG_AW-1:0] id_rt;

	// Decode/execute latch
	logic [`MIPS_WORD_W-1:0] ex_operand_a;
	logic [`MIPS_WORD_W-1:0] ex_operand_b;
	logic [`MIPS_WORD_W-1:0] ex_store_data;
	logic [`MIPS_WORD_W-1:0] ex_imm;
	logic                    ex_use_imm;
	alu_op_t                 ex_alu_op;
	logic [`MIPS_REG_AW-1:0] ex_rs;
	logic [`MIPS_REG_AW-1:0] ex_rt;
	logic [`MIPS_REG_AW-1:0] ex_dest;
	logic                    ex_reg_write;
	logic                    ex_mem_read;
	logic                    ex_mem_write;
	logic                    ex_branch;
	logic [`MIPS_WORD_W-1:0] ex_pc_plus4;

	// Branch resolved in execute
	logic                    branch_taken;
	logic [`MIPS_WORD_W-1:0] branch_target;

	// Execute/memory and memory/writeback latches
	stage_result_if mem_stage ();
	stage_result_if wb_stage ();

	//------------------------------------------------------------
	// Stages
	//------------------------------------------------------------
	fetch fetch_stage (
		.clock               (clock),
		.rst                 (rst),
		.stall               (stall),
		.flush               (flush),
		.branch_taken        (branch_taken),
		.branch_target       (branch_target),
		.instruction_in      (instruction_in),
		.instruction_address (instruction_address),
		.id_instr            (id_instr),
		.id_pc_plus4         (id_pc_plus4)
	);

	decode decode_stage (
		.clock         (clock),
		.rst           (rst),
		.stall         (stall),
		.flush         (flush),
		.id_instr      (id_instr),
		.id_pc_plus4   (id_pc_plus4),
		.wb            (wb_stage.monitor),
		.ex_operand_a  (ex_operand_a),
		.ex_operand_b  (ex_operand_b),
		.ex_store_data (ex_store_data),
		.ex_imm        (ex_imm),
		.ex_use_imm    (ex_use_imm),
		.ex_alu_op     (ex_alu_op),
		.ex_rs         (ex_rs),
		.ex_rt         (ex_rt),
		.ex_dest       (ex_dest),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.ex_branch     (ex_branch),
		.ex_pc_plus4   (ex_pc_plus4),
		.id_rs         (id_rs),
		.id_rt         (id_rt)
	);

	execute execute_stage (
		.clock         (clock),
		.rst           (rst),
		.ex_operand_a  (ex_operand_a),
		.ex_operand_b  (ex_operand_b),
		.ex_store_data (ex_store_data),
		.ex_imm        (ex_imm),
		.ex_use_imm    (ex_use_imm),
		.ex_alu_op     (ex_alu_op),
		.ex_dest       (ex_dest),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.ex_branch     (ex_branch),
		.ex_pc_plus4   (ex_pc_plus4),
		.sel_a         (sel_a),
		.sel_b         (sel_b),
		.data_in       (data_in),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.data_address  (data_address),
		.data_out      (data_out),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_stage     (mem_stage.source),
		.wb_stage      (wb_stage.source)
	);

	hazard_unit hazards (
		.id_rs        (id_rs),
		.id_rt        (id_rt),
		.ex_rs        (ex_rs),
		.ex_rt        (ex_rt),
		.ex_dest      (ex_dest),
		.ex_mem_read  (ex_mem_read),
		.branch_taken (branch_taken),
		.mem_stage    (mem_stage.monitor),
		.wb_stage     (wb_stage.monitor),
		.sel_a        (sel_a),
		.sel_b        (sel_b),
		.stall        (stall),
		.flush        (flush)
	);

endmodule

// ==== verilog/mips_if.sv ====
/* Write-back information of one pipeline latch. Driven by execute,
   watched by the hazard unit, and by decode for the register write. */
`timescale 1ns/1ps
`include "mips_settings.svh"

interface stage_result_if;

	// Instruction in this latch writes a register
	logic                    reg_write;
	logic [`MIPS_REG_AW-1:0] dest;
	// ALU result, or load data once past memory
	logic [`MIPS_WORD_W-1:0] value;
	logic                    is_load;
	// Clear for a bubble
	logic                    valid;

	modport source (
		output reg_write,
		output dest,
		output value,
		output is_load,
		output valid
	);

	modport monitor (
		input reg_write,
		input dest,
		input value,
		input is_load,
		input valid
	);

endinterface

// ==== verilog/mips_pkg.sv ====
/* Shared pipeline types: the instruction word with its R and I views,
   opcode and function encodings, ALU operations and forward sources. */
`include "mips_settings.svh"

package mips_pkg;

	// Opcode width follows the field bounds
	localparam int OPCODE_W = `MIPS_OPCODE_MSB - `MIPS_OPCODE_LSB + 1;

	// Supported primary opcodes
	typedef enum logic [OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_ADDIU   = 6'h09,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	// Function codes under OP_SPECIAL
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_t;

	// Where an execute operand comes from
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// Register-register layout
	typedef struct packed {
		opcode_t                 opcode;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [`MIPS_REG_AW-1:0] rd;
		logic [4:0]              shamt;
		funct_t                  funct;
	} r_view_t;

	// Immediate layout
	typedef struct packed {
		opcode_t                 opcode;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [15:0]             imm;
	} i_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
	} instr_t;

endpackage

// ==== verilog/mips_settings.svh ====
/* Global widths, reset address and instruction field bounds for the
   pipelined MIPS core. Included by the package and every RTL file. */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data and address width
`define MIPS_WORD_W 32

// Register file geometry
`define MIPS_REG_AW 5
`define MIPS_REG_COUNT 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// Opcode field bounds within an instruction word
`define MIPS_OPCODE_MSB 31
`define MIPS_OPCODE_LSB 26

`endif

// ==== verilog/reg_file.sv ====
/* 32-entry register file, two read ports and one write port.
   A same-cycle write is passed straight to the reads. */
`timescale 1ns/1ps
`include "mips_settings.svh"

module reg_file (
	input  logic                    clock,
	input  logic                    rst,
	input  logic [`MIPS_REG_AW-1:0] read_a,
	input  logic [`MIPS_REG_AW-1:0] read_b,
	input  logic                    write_en,
	input  logic [`MIPS_REG_AW-1:0] write_addr,
	input  logic [`MIPS_WORD_W-1:0] write_data,
	output logic [`MIPS_WORD_W-1:0] value_a,
	output logic [`MIPS_WORD_W-1:0] value_b
);

	logic [`MIPS_WORD_W-1:0] regs [`MIPS_REG_COUNT];

	// Register zero reads zero, pending write wins over array
	function automatic logic [`MIPS_WORD_W-1:0] read_port(input logic [`MIPS_REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		if (write_en && write_addr == addr)
			return write_data;
		return regs[addr];
	endfunction

	assign value_a = read_port(read_a);
	assign value_b = read_port(read_b);

	// No writes while in reset, never to register zero
	always_ff @(posedge clock) begin
		if (!rst && write_en && write_addr != '0)
			regs[write_addr] <= write_data;
	end

endmodule
